/* all.f */
design/dac_tx_pkg.sv
design/tx_sample_pacer.sv
design/cdc_async_fifo.sv
design/cdc_flag_sync.sv
design/dac_lane_packer.sv
design/dac_tx_intf.sv
verif/dac_tx_intf_tb.sv

/* design/cdc_async_fifo.sv */
// dual clock first-word-fall-through fifo with gray pointers, carrying samples from acc_clk to dac_clk
module cdc_async_fifo (
    input  logic                            acc_clk,
    input  logic                            acc_rstn,
    input  logic                            wr_en,
    input  logic [dac_tx_pkg::SAMPLE_W-1:0] wr_data,
    input  logic                            dac_clk,
    input  logic                            dac_rst,
    input  logic                            rd_en,
    output logic [dac_tx_pkg::SAMPLE_W-1:0] rd_data,
    output logic                            full,
    output logic                            empty
);
    import dac_tx_pkg::*;

    logic [SAMPLE_W-1:0] mem [FIFO_DEPTH];       // storage, written in acc_clk

    // write side, acc_clk
    logic [FIFO_AW:0] wr_bin;                     // extra msb tells wrap from full
    logic [FIFO_AW:0] wr_bin_nxt;
    logic [FIFO_AW:0] wr_gray;
    logic [FIFO_AW:0] wr_gray_nxt;
    logic [FIFO_AW:0] rd_gray_sync [FIFO_SYNC_STAGES]; // read pointer on its way in
    logic [FIFO_AW:0] rd_gray_acc;                // read pointer as seen by acc_clk

    // read side, dac_clk
    logic [FIFO_AW:0] rd_bin;
    logic [FIFO_AW:0] rd_bin_nxt;
    logic [FIFO_AW:0] rd_gray;
    logic [FIFO_AW:0] rd_gray_nxt;
    logic [FIFO_AW:0] wr_gray_sync [FIFO_SYNC_STAGES]; // write pointer on its way in
    logic [FIFO_AW:0] wr_gray_dac;                // write pointer as seen by dac_clk

    assign wr_bin_nxt  = wr_bin + {{FIFO_AW{1'b0}}, wr_en};
    assign wr_gray_nxt = (wr_bin_nxt >> 1) ^ wr_bin_nxt;   // binary to gray
    assign rd_bin_nxt  = rd_bin + {{FIFO_AW{1'b0}}, rd_en};
    assign rd_gray_nxt = (rd_bin_nxt >> 1) ^ rd_bin_nxt;

    // write pointer pair
    always_ff @(posedge acc_clk) begin
        if (!acc_rstn) begin
            wr_bin  <= '0;
            wr_gray <= '0;
        end else begin
            wr_bin  <= wr_bin_nxt;
            wr_gray <= wr_gray_nxt;   // only one bit moves per write
        end
    end

    always_ff @(posedge acc_clk) begin
        if (wr_en) begin
            mem[wr_bin[FIFO_AW-1:0]] <= wr_data;
        end
    end

    // read gray pointer into acc_clk
    always_ff @(posedge acc_clk) begin
        if (!acc_rstn) begin
            for (int i = 0; i < FIFO_SYNC_STAGES; i++) begin
                rd_gray_sync[i] <= '0;
            end
        end else begin
            rd_gray_sync[0] <= rd_gray;
            for (int i = 1; i < FIFO_SYNC_STAGES; i++) begin
                rd_gray_sync[i] <= rd_gray_sync[i-1];
            end
        end
    end

    assign rd_gray_acc = rd_gray_sync[FIFO_SYNC_STAGES-1];

    // full when the pointers differ only in the two top gray bits
    assign full = (wr_gray == {~rd_gray_acc[FIFO_AW:FIFO_AW-1], rd_gray_acc[FIFO_AW-2:0]});

    // read pointer pair
    always_ff @(posedge dac_clk) begin
        if (dac_rst) begin
            rd_bin  <= '0;
            rd_gray <= '0;
        end else begin
            rd_bin  <= rd_bin_nxt;
            rd_gray <= rd_gray_nxt;
        end
    end

    // write gray pointer into dac_clk
    always_ff @(posedge dac_clk) begin
        if (dac_rst) begin
            for (int i = 0; i < FIFO_SYNC_STAGES; i++) begin
                wr_gray_sync[i] <= '0;
            end
        end else begin
            wr_gray_sync[0] <= wr_gray;
            for (int i = 1; i < FIFO_SYNC_STAGES; i++) begin
                wr_gray_sync[i] <= wr_gray_sync[i-1];
            end
        end
    end

    assign wr_gray_dac = wr_gray_sync[FIFO_SYNC_STAGES-1];

    assign empty   = (rd_gray == wr_gray_dac);       // pessimistic until the write pointer lands
    assign rd_data = mem[rd_bin[FIFO_AW-1:0]];        // head word shows without a read

    // upstream never stalls so the dac side has to keep pace
    assert property (@(posedge acc_clk) disable iff (!acc_rstn) wr_en |-> !full)
        else $error("fifo write while full");

    assert property (@(posedge dac_clk) disable iff (dac_rst) rd_en |-> !empty)
        else $error("fifo read while empty");

endmodule

/* design/cdc_flag_sync.sv */
// carries the antenna select and cdd enable levels from acc_clk into dac_clk through flop chains
module cdc_flag_sync (
    input  logic acc_clk,
    input  logic acc_rstn,
    input  logic dac_clk,
    input  logic dac_rst,
    input  logic ant_flag,         // level in acc_clk
    input  logic simple_cdd_flag,  // level in acc_clk
    output logic ant_sel,          // ant_flag in dac_clk
    output logic cdd_en            // simple_cdd_flag in dac_clk
);
    import dac_tx_pkg::*;

    logic                        ant_src;    // launch flop, glitch free source
    logic                        cdd_src;
    logic [FLAG_SYNC_STAGES-1:0] ant_chain;  // bit 0 is the metastable catch flop
    logic [FLAG_SYNC_STAGES-1:0] cdd_chain;

    always_ff @(posedge acc_clk) begin
        if (!acc_rstn) begin
            ant_src <= 1'b0;
            cdd_src <= 1'b0;
        end else begin
            ant_src <= ant_flag;
            cdd_src <= simple_cdd_flag;
        end
    end

    always_ff @(posedge dac_clk) begin
        if (dac_rst) begin
            ant_chain <= '0;
            cdd_chain <= '0;
        end else begin
            ant_chain <= {ant_chain[FLAG_SYNC_STAGES-2:0], ant_src};
            cdd_chain <= {cdd_chain[FLAG_SYNC_STAGES-2:0], cdd_src};
        end
    end

    assign ant_sel = ant_chain[FLAG_SYNC_STAGES-1];  // last stage is settled
    assign cdd_en  = cdd_chain[FLAG_SYNC_STAGES-1];

endmodule

/* design/dac_lane_packer.sv */
// dac_clk stage that pops the fifo on each dac handshake and places words into the two lane dac word
module dac_lane_packer (
    input  logic                            dac_clk,
    input  logic                            dac_rst,
    input  logic [dac_tx_pkg::SAMPLE_W-1:0] fifo_rd_data,  // fwft head word
    input  logic                            fifo_empty,
    output logic                            fifo_rd_en,
    input  logic                            ant_sel,       // 1 puts the stream on the upper lane
    input  logic                            cdd_en,        // drive both lanes with one delayed
    output logic [dac_tx_pkg::DAC_W-1:0]    dac_data,
    output logic                            dac_valid,
    input  logic                            dac_ready
);
    import dac_tx_pkg::*;

    logic                xfer;        // word accepted by the dac this cycle
    logic [SAMPLE_W-1:0] prev_word;   // word of the last transfer
    logic [SAMPLE_W-1:0] prev2_word;  // word two transfers back, previous baseband sample

    assign dac_valid  = !fifo_empty;         // head word is valid whenever fifo holds one
    assign xfer       = dac_valid & dac_ready;
    assign fifo_rd_en = xfer;                // pop exactly on a transfer

    // delay line advances only with the stream
    always_ff @(posedge dac_clk) begin
        if (dac_rst) begin
            prev_word  <= '0;
            prev2_word <= '0;
        end else if (xfer) begin
            prev_word  <= fifo_rd_data;
            prev2_word <= prev_word;
        end
    end

    // lane placement
    always_comb begin
        if (cdd_en) begin
            dac_data = {prev2_word, fifo_rd_data};          // upper lane one sample late
        end else if (ant_sel) begin
            dac_data = {fifo_rd_data, {SAMPLE_W{1'b0}}};    // antenna 1 only
        end else begin
            dac_data = {{SAMPLE_W{1'b0}}, fifo_rd_data};    // antenna 0 only
        end
    end

    // the dac side must never pull from the fifo before a word has crossed over
    assert property (@(posedge dac_clk) disable iff (dac_rst) fifo_rd_en |-> !fifo_empty)
        else $error("packer popped an empty fifo");

    // an offered word stays put until the dac takes it
    assert property (@(posedge dac_clk) disable iff (dac_rst)
        (dac_valid && !dac_ready) |=> (dac_valid && $stable(fifo_rd_data)))
        else $error("dac word dropped or changed while stalled");

endmodule

/* design/dac_tx_intf.sv */
// transmit dac interface top, pacing modem samples in acc_clk and packing two lane words in dac_clk
module dac_tx_intf (
    // modem side
    input  logic                            acc_clk,
    input  logic                            acc_rstn,
    input  logic [dac_tx_pkg::SAMPLE_W-1:0] data_from_acc,   // baseband fifo head
    output logic                            read_bb_fifo,    // baseband fifo pop
    input  logic                            ant_flag,
    input  logic                            simple_cdd_flag,
    // dac side
    input  logic                            dac_clk,
    input  logic                            dac_rst,
    output logic [dac_tx_pkg::DAC_W-1:0]    dac_data,
    output logic                            dac_valid,
    input  logic                            dac_ready
);
    import dac_tx_pkg::*;

    logic                fifo_wr_en;     // acc_clk, sample then zero
    logic [SAMPLE_W-1:0] fifo_wr_data;
    logic                fifo_rd_en;     // dac_clk, one per transfer
    logic [SAMPLE_W-1:0] fifo_rd_data;
    logic                fifo_empty;
    logic                ant_sel;        // flags after crossing
    logic                cdd_en;

    tx_sample_pacer tx_sample_pacer_i (
        .acc_clk       (acc_clk),
        .acc_rstn      (acc_rstn),
        .data_from_acc (data_from_acc),
        .read_bb_fifo  (read_bb_fifo),
        .fifo_wr_en    (fifo_wr_en),
        .fifo_wr_data  (fifo_wr_data)
    );

    cdc_async_fifo cdc_async_fifo_i (
        .acc_clk  (acc_clk),
        .acc_rstn (acc_rstn),
        .wr_en    (fifo_wr_en),
        .wr_data  (fifo_wr_data),
        .dac_clk  (dac_clk),
        .dac_rst  (dac_rst),
        .rd_en    (fifo_rd_en),
        .rd_data  (fifo_rd_data),
        .full     (),              // pacer has no stall path
        .empty    (fifo_empty)
    );

    cdc_flag_sync cdc_flag_sync_i (
        .acc_clk         (acc_clk),
        .acc_rstn        (acc_rstn),
        .dac_clk         (dac_clk),
        .dac_rst         (dac_rst),
        .ant_flag        (ant_flag),
        .simple_cdd_flag (simple_cdd_flag),
        .ant_sel         (ant_sel),
        .cdd_en          (cdd_en)
    );

    dac_lane_packer dac_lane_packer_i (
        .dac_clk      (dac_clk),
        .dac_rst      (dac_rst),
        .fifo_rd_data (fifo_rd_data),
        .fifo_empty   (fifo_empty),
        .fifo_rd_en   (fifo_rd_en),
        .ant_sel      (ant_sel),
        .cdd_en       (cdd_en),
        .dac_data     (dac_data),
        .dac_valid    (dac_valid),
        .dac_ready    (dac_ready)
    );

endmodule

/* design/dac_tx_pkg.sv */
// shared widths, fifo depth, sample pacing and synchronizer depths for the dac transmit path
package dac_tx_pkg;

    // sample format
    localparam int IQ_W     = 16;           // one i or q component
    localparam int SAMPLE_W = 2 * IQ_W;     // packed iq sample as delivered by the modem
    localparam int DAC_W    = 2 * SAMPLE_W; // two antenna lanes side by side

    // acc_clk pacing
    localparam int CLK_PER_SAMPLE = 5;      // 100 MHz acc_clk down to 20 Msps baseband
    localparam int PHASE_W        = $clog2(CLK_PER_SAMPLE); // phase counter width

    // dual clock fifo between acc_clk and dac_clk
    localparam int FIFO_DEPTH       = 32;   // words
    localparam int FIFO_AW          = 5;    // log2 of FIFO_DEPTH
    localparam int FIFO_SYNC_STAGES = 2;    // gray pointer synchronizer depth

    // control flag crossing
    localparam int FLAG_SYNC_STAGES = 4;    // dac_clk flops per flag

endpackage

/* design/tx_sample_pacer.sv */
// acc_clk pacer that pops one baseband sample per sample period and writes it plus a stuffed zero
module tx_sample_pacer (
    input  logic                            acc_clk,
    input  logic                            acc_rstn,
    input  logic [dac_tx_pkg::SAMPLE_W-1:0] data_from_acc,  // head of upstream fwft fifo
    output logic                            read_bb_fifo,   // one cycle pop strobe
    output logic                            fifo_wr_en,     // two cycle write burst
    output logic [dac_tx_pkg::SAMPLE_W-1:0] fifo_wr_data
);
    import dac_tx_pkg::*;

    logic [PHASE_W-1:0] phase;        // position inside the sample period
    logic               phase_last;   // final cycle of the period
    logic               take_sample;  // phase 0 slot carries the real sample
    logic               stuff_zero;   // phase 1 slot carries the inserted zero

    assign phase_last  = (phase == PHASE_W'(CLK_PER_SAMPLE - 1));
    assign take_sample = (phase == '0);
    assign stuff_zero  = (phase == PHASE_W'(1));

    // modulo CLK_PER_SAMPLE phase counter
    always_ff @(posedge acc_clk) begin
        if (!acc_rstn) begin
            phase <= '0;
        end else if (phase_last) begin
            phase <= '0;                         // wrap to start of next sample
        end else begin
            phase <= phase + PHASE_W'(1);
        end
    end

    // strobes are registered off the phase decode
    always_ff @(posedge acc_clk) begin
        if (!acc_rstn) begin
            read_bb_fifo <= 1'b0;
            fifo_wr_en   <= 1'b0;
        end else begin
            read_bb_fifo <= take_sample;              // pop lines up with the capture
            fifo_wr_en   <= take_sample | stuff_zero; // sample then zero, 2x interpolation
        end
    end

    // write word follows the strobe by construction
    always_ff @(posedge acc_clk) begin
        if (take_sample) begin
            fifo_wr_data <= data_from_acc;  // capture head word on the pop edge
        end else begin
            fifo_wr_data <= '0;             // zero stuffing slot and idle cycles
        end
    end

    // the write burst is two words per period, a third would overrun the dac rate
    assert property (@(posedge acc_clk) disable iff (!acc_rstn)
        (fifo_wr_en && $past(fifo_wr_en)) |=> !fifo_wr_en)
        else $error("pacer wrote three words in a row");

endmodule

/* run_sim.sh */
#!/bin/sh
# Builds the dac transmit testbench with Verilator, runs it into sim.log
# and decides pass or fail from the log.

cd "$(dirname "$0")" || exit 1

TOP=dac_tx_intf_tb
BUILD_LOG=build.log
SIM_LOG=sim.log

rm -rf obj_dir "$BUILD_LOG" "$SIM_LOG"

verilator --binary --timing --assert \
    --top-module "$TOP" \
    -f all.f > "$BUILD_LOG" 2>&1
status=$?
if [ $status -ne 0 ]; then
    echo "build failed with status $status, see $BUILD_LOG"
    exit 1
fi

if [ ! -x "obj_dir/V$TOP" ]; then
    echo "simulation binary obj_dir/V$TOP is missing"
    exit 1
fi

"./obj_dir/V$TOP" > "$SIM_LOG" 2>&1
status=$?
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status, see $SIM_LOG"
    exit 1
fi

if grep -qx "All checks passed" "$SIM_LOG"; then
    echo "PASS"
    exit 0
fi

echo "FAIL, see $SIM_LOG"
exit 1

/* verif/dac_tx_intf_tb.sv */
// directed testbench for dac_tx_intf, models the baseband fifo and the dac consumer, built from all.f
module dac_tx_intf_tb;
    import dac_tx_pkg::*;

    localparam int SAMPLES_PER_TEST = 48;  // baseband samples per streaming test
    localparam int RESET_SAMPLES    = 8;   // pacer pulses watched right after reset
    localparam int SETTLE_SAMPLES   = 4;   // drain plus flag settle, in sample periods
    localparam int TOTAL_SAMPLES    = 4 * (SAMPLES_PER_TEST + SETTLE_SAMPLES) + RESET_SAMPLES;
    localparam int TIMEOUT          = TOTAL_SAMPLES * CLK_PER_SAMPLE * 10 * 4;
    localparam logic [31:0] SEED    = 32'h686f_284f;

    logic                acc_clk = 1'b0;
    logic                dac_clk = 1'b0;
    logic                acc_rstn;
    logic                dac_rst;
    logic [SAMPLE_W-1:0] data_from_acc;
    logic                read_bb_fifo;
    logic                ant_flag;
    logic                simple_cdd_flag;
    logic [DAC_W-1:0]    dac_data;
    logic                dac_valid;
    logic                dac_ready;

    logic [31:0]         sample_lfsr;         // feeds the baseband samples
    logic [31:0]         ready_lfsr;          // feeds the random dac_ready
    logic [SAMPLE_W-1:0] bb_q [$];            // upstream fifo contents, head on data_from_acc
    logic [SAMPLE_W-1:0] ref_q [$];           // expected stream, sample then zero
    logic [SAMPLE_W-1:0] hist1;               // expected word of the last transfer
    logic [SAMPLE_W-1:0] hist2;               // and the one before it
    logic [DAC_W-1:0]    stalled_data;        // word offered while dac_ready was low
    logic                stalled      = 1'b0;
    logic                after_rst    = 1'b0; // first dac cycle out of reset
    logic                prev_read    = 1'b0;
    logic                exp_ant      = 1'b0; // flags the checker expects
    logic                exp_cdd      = 1'b0;
    logic                settling     = 1'b0; // flags in flight, any layout accepted
    logic                random_ready = 1'b0;
    int                  value_errors = 0;
    int                  other_errors = 0;
    int                  xfer_count   = 0;
    int                  acc_cycle    = 0;
    int                  last_pulse   = -1;
    int                  pulse_count  = 0;
    int                  low_run      = 0;    // dac_ready low cycles in a row

    always #5 acc_clk = ~acc_clk;             // 100 MHz modem side
    always #6 dac_clk = ~dac_clk;             // dac side, unrelated phase

    dac_tx_intf dac_tx_intf_i (
        .acc_clk         (acc_clk),
        .acc_rstn        (acc_rstn),
        .data_from_acc   (data_from_acc),
        .read_bb_fifo    (read_bb_fifo),
        .ant_flag        (ant_flag),
        .simple_cdd_flag (simple_cdd_flag),
        .dac_clk         (dac_clk),
        .dac_rst         (dac_rst),
        .dac_data        (dac_data),
        .dac_valid       (dac_valid),
        .dac_ready       (dac_ready)
    );

    // fibonacci lfsr x^32 + x^22 + x^2 + x + 1, one step per bit
    function automatic logic lfsr_step(inout logic [31:0] state);
        logic fb;
        fb    = state[31] ^ state[21] ^ state[1] ^ state[0];
        state = {state[30:0], fb};
        return fb;
    endfunction

    function automatic logic [SAMPLE_W-1:0] random_sample();
        logic [SAMPLE_W-1:0] w;
        w = '0;
        for (int i = 0; i < SAMPLE_W; i++) begin
            w = {w[SAMPLE_W-2:0], lfsr_step(sample_lfsr)};  // one bit per step
        end
        return w;
    endfunction

    // lane placement table: cdd pairs the word two transfers back with the current one
    function automatic logic [DAC_W-1:0] expected_word(input logic cdd, input logic ant,
            input logic [SAMPLE_W-1:0] cur, input logic [SAMPLE_W-1:0] older);
        if (cdd) begin
            return {older, cur};
        end
        if (ant) begin
            return {cur, SAMPLE_W'(0)};
        end
        return {SAMPLE_W'(0), cur};
    endfunction

    task automatic value_mismatch(input string msg);
        value_errors++;
        $display("CHECK FAILED at %0t: %s", $time, msg);
    endtask

    task automatic raise_problem(input string msg);
        other_errors++;
        $display("ERROR at %0t: %s", $time, msg);
    endtask

    // baseband fifo model and pacing monitor
    always @(negedge acc_clk) begin
        if (!acc_rstn) begin
            assert (!read_bb_fifo) else value_mismatch("read_bb_fifo high during reset");
            acc_cycle  = 0;
            last_pulse = -1;
            prev_read  = 1'b0;
        end else begin
            acc_cycle++;
            if (read_bb_fifo) begin
                assert (!prev_read) else value_mismatch("read_bb_fifo longer than one cycle");
                if (last_pulse < 0) begin
                    assert (acc_cycle == 1)
                        else value_mismatch($sformatf("first pop on cycle %0d", acc_cycle));
                end else begin
                    assert (acc_cycle - last_pulse == CLK_PER_SAMPLE)
                        else value_mismatch($sformatf("pops %0d cycles apart",
                            acc_cycle - last_pulse));
                end
                last_pulse = acc_cycle;
                pulse_count++;
                ref_q.push_back(bb_q[0]);          // captured on the edge that raised the strobe
                ref_q.push_back(SAMPLE_W'(0));     // stuffed zero follows
                void'(bb_q.pop_front());
                bb_q.push_back(random_sample());   // upstream never runs dry
                data_from_acc <= bb_q[0];
            end
            prev_read = read_bb_fifo;
        end
    end

    // dac consumer and output checker
    always @(negedge dac_clk) begin : consumer
        logic                ready_now;
        logic                bit_a;
        logic                bit_b;
        logic [SAMPLE_W-1:0] cur;
        logic [DAC_W-1:0]    want;
        if (dac_rst) begin
            assert (!dac_valid) else value_mismatch("dac_valid high during reset");
            hist1     = '0;
            hist2     = '0;
            stalled   = 1'b0;
            low_run   = 0;
            after_rst = 1'b1;
        end else begin
            if (after_rst) begin
                assert (!dac_valid) else value_mismatch("dac_valid high right after reset");
                after_rst = 1'b0;
            end
            if (stalled && !settling) begin
                assert (dac_valid && dac_data == stalled_data)
                    else value_mismatch($sformatf("stalled word %h became %h valid %b",
                        stalled_data, dac_data, dac_valid));
            end
            ready_now = 1'b1;
            if (random_ready && low_run < 5) begin  // low runs stay under 6 cycles
                bit_a     = lfsr_step(ready_lfsr);
                bit_b     = lfsr_step(ready_lfsr);
                ready_now = bit_a | bit_b;           // high three times in four
            end
            low_run   = ready_now ? 0 : low_run + 1;
            dac_ready <= ready_now;
            stalled   = 1'b0;
            if (dac_valid && ready_now) begin
                xfer_count++;
                assert (ref_q.size() != 0)
                    else raise_problem("dac transferred a word that was never sent");
                if (ref_q.size() != 0) begin
                    cur  = ref_q.pop_front();
                    want = expected_word(exp_cdd, exp_ant, cur, hist2);
                    if (settling) begin
                        assert (dac_data == expected_word(1'b0, 1'b0, cur, hist2) ||
                                dac_data == expected_word(1'b0, 1'b1, cur, hist2) ||
                                dac_data == expected_word(1'b1, 1'b0, cur, hist2))
                            else value_mismatch($sformatf("transfer %0d: %h fits no layout",
                                xfer_count, dac_data));
                    end else begin
                        assert (dac_data == want)
                            else value_mismatch($sformatf("transfer %0d: got %h, want %h",
                                xfer_count, dac_data, want));
                    end
                    hist2 = hist1;
                    hist1 = cur;
                end
            end else if (dac_valid) begin
                stalled      = 1'b1;
                stalled_data = dac_data;
            end
        end
    end

    task automatic check_reset_and_pacing();
        repeat (16) @(negedge acc_clk);
        acc_rstn <= 1'b1;
        @(negedge dac_clk);
        dac_rst <= 1'b0;
        repeat (RESET_SAMPLES * CLK_PER_SAMPLE - 1) @(negedge acc_clk);
        assert (pulse_count == RESET_SAMPLES)
            else value_mismatch($sformatf("%0d pops after reset, want %0d",
                pulse_count, RESET_SAMPLES));
    endtask

    // empty the output, switch the flags, let them cross
    task automatic change_flags(input logic ant, input logic cdd);
        random_ready = 1'b0;
        @(negedge dac_clk);
        while (dac_valid) @(negedge dac_clk);
        @(negedge acc_clk);
        ant_flag        <= ant;
        simple_cdd_flag <= cdd;
        exp_ant  = ant;
        exp_cdd  = cdd;
        settling = 1'b1;
        repeat (2 + 2 * FLAG_SYNC_STAGES) @(negedge dac_clk);  // 1 acc + 4 dac with margin
        settling = 1'b0;
    endtask

    task automatic run_stream(input logic ant, input logic cdd, input logic rnd,
            input string name);
        int target;
        change_flags(ant, cdd);
        random_ready = rnd;
        target = xfer_count + 2 * SAMPLES_PER_TEST;
        while (xfer_count < target) @(negedge dac_clk);
        $display("%s: %0d transfers compared", name, 2 * SAMPLES_PER_TEST);
    endtask

    initial begin : watchdog
        #(TIMEOUT);
        raise_problem($sformatf("run did not finish within %0d time units", TIMEOUT));
        $display("errors: %0d value, %0d other", value_errors, other_errors);
        $display("Checks failed");
        $finish;
    end

    initial begin
        acc_rstn        = 1'b0;
        dac_rst         = 1'b1;
        ant_flag        = 1'b0;
        simple_cdd_flag = 1'b0;
        dac_ready       = 1'b0;
        sample_lfsr     = SEED;
        ready_lfsr      = SEED;
        bb_q.push_back(random_sample());
        data_from_acc   = bb_q[0];

        check_reset_and_pacing();
        run_stream(1'b0, 1'b0, 1'b0, "lane 0");
        run_stream(1'b1, 1'b0, 1'b0, "lane 1");
        run_stream(1'b0, 1'b1, 1'b0, "cyclic delay");
        run_stream(1'b0, 1'b1, 1'b1, "back-pressure");

        $display("errors: %0d value, %0d other", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule
